// ==== Makefile ====
# Verilator build and run of the 6502-style core testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run tb_cpu and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_cpu -f list.f
	./obj_dir/Vtb_cpu > $(LOG) 2>&1 || echo "Checks failed" >> $(LOG)
	@cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@echo "TEST PASSED"

clean:
	rm -rf obj_dir $(LOG)

// ==== dv/cpu_asserts.sv ====
// Memory port handshake, command stability and halt assertions bound to cpu_top
`timescale 1ns/1ps

module cpu_asserts import cpu_pkg::*; (
    input logic     phi0,
    input logic     rst_n,
    input logic     mem_req,
    input logic     mem_ack,
    input mem_cmd_t mem_cmd,
    input logic     halted
);

    ////////////////////
    // Four-phase handshake

    // Req held until the memory answers
    req_held: assert property (@(posedge phi0) disable iff (!rst_n)
        mem_req && !mem_ack |=> mem_req)
        else $error("mem_req dropped before mem_ack");

    // Ack may only fall once req is gone
    ack_held: assert property (@(posedge phi0) disable iff (!rst_n)
        $fell(mem_ack) |-> !mem_req)
        else $error("mem_ack dropped while mem_req was high");

    cmd_stable: assert property (@(posedge phi0) disable iff (!rst_n)
        mem_req |=> !mem_req || $stable(mem_cmd))
        else $error("mem_cmd changed while mem_req was high");

    ////////////////////
    // Halt

    // Only reset clears halted
    halt_sticky: assert property (@(posedge phi0)
        rst_n && halted |=> halted)
        else $error("halted fell without reset");

endmodule

bind cpu_top cpu_asserts u_asserts (
    .phi0    (phi0),
    .rst_n   (rst_n),
    .mem_req (mem_req),
    .mem_ack (mem_ack),
    .mem_cmd (mem_cmd),
    .halted  (halted)
);

// ==== dv/cpu_testdata.txt ====
// Columns are kind, address and byte in hex
// P loads a program byte, W is the next expected memory write in order
P 0200 A9 // LDA #$3C
P 0201 3C
P 0202 8D // STA $0300
P 0203 00
P 0204 03
P 0205 18 // CLC
P 0206 A9 // LDA #$F0
P 0207 F0
P 0208 69 // ADC #$20
P 0209 20
P 020A 8D // STA $0301
P 020B 01
P 020C 03
P 020D A9 // LDA #$00
P 020E 00
P 020F 69 // ADC #$00 picks up the carry
P 0210 00
P 0211 8D // STA $0302
P 0212 02
P 0213 03
P 0214 A9 // LDA #$C7
P 0215 C7
P 0216 29 // AND #$3C
P 0217 3C
P 0218 AA // TAX
P 0219 E8 // INX
P 021A 8E // STX $0303
P 021B 03
P 021C 03
P 021D A9 // LDA #$FF
P 021E FF
P 021F 29 // AND #$FF
P 0220 FF
P 0221 AA // TAX
P 0222 E8 // INX wraps to zero
P 0223 8E // STX $0304
P 0224 04
P 0225 03
P 0226 AD // LDA $0400
P 0227 00
P 0228 04
P 0229 8D // STA $0305
P 022A 05
P 022B 03
P 022C 4C // JMP $0280
P 022D 80
P 022E 02
P 022F 8D // STA $0306 is skipped
P 0230 06
P 0231 03
P 0280 A9 // LDA #$77
P 0281 77
P 0282 8D // STA $0307
P 0283 07
P 0284 03
P 0285 00 // BRK
P 0400 A5
W 0300 3C
W 0301 10
W 0302 01
W 0303 05
W 0304 00
W 0305 A5
W 0307 77

// ==== dv/tb_cpu.sv ====
// Testbench for cpu_top with clock, reset, memory model, test data loading and write checks
`timescale 1ns/1ps

module tb_cpu import cpu_pkg::*; ();

    localparam int halt_timeout = 20000;
    localparam int ack_timeout  = 100;
    localparam int quiet_cycles = 50;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
    } write_t;

    typedef enum logic [1:0] {
        mem_idle,
        mem_delay,
        mem_acked
    } mem_phase_e;

    logic              phi0;
    logic              rst_n;
    logic              mem_req;
    mem_cmd_t          mem_cmd;
    logic              mem_ack;
    logic [data_w-1:0] mem_rdata;
    logic              halted;

    logic [data_w-1:0] mem [0:65535];
    write_t            exp_writes[$];
    mem_phase_e        mem_phase;
    int unsigned       delay_left;
    int                hold_cycles;

    cpu_top DUT (
        .phi0      (phi0),
        .rst_n     (rst_n),
        .mem_req   (mem_req),
        .mem_cmd   (mem_cmd),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .halted    (halted)
    );

    initial phi0 = 1'b0;
    always #50 phi0 = ~phi0;

    ////////////////////
    // Failure reporting

    task automatic stop_with_failure();
        $display("Checks failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_equal(input string what, input logic [addr_w-1:0] got,
                               input logic [addr_w-1:0] expected);
        if (got !== expected) begin
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, expected);
            stop_with_failure();
        end
    endtask

    // Writes must arrive in program order
    task automatic check_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
        write_t exp;
        if (exp_writes.size() == 0) begin
            $display("[FAIL] %0t ns: unexpected write of %h to %h", $time, data, addr);
            stop_with_failure();
        end
        exp = exp_writes.pop_front();
        check_equal("write address", addr, exp.addr);
        check_equal("write data", {{(addr_w-data_w){1'b0}}, data},
                    {{(addr_w-data_w){1'b0}}, exp.data});
    endtask

    ////////////////////
    // Test data

    task automatic load_testdata();
        int                fd;
        int                n;
        string             line;
        logic [7:0]        kind;
        logic [addr_w-1:0] rec_addr;
        logic [data_w-1:0] rec_val;
        write_t            wr;
        // Background pattern so stray reads stand out
        for (int i = 0; i < 65536; i++) begin
            mem[i] = i[7:0] ^ i[15:8];
        end
        fd = $fopen("dv/cpu_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file dv/cpu_testdata.txt");
            stop_with_failure();
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%c %h %h", kind, rec_addr, rec_val);
                if (n == 3 && kind == "P") begin
                    mem[rec_addr] = rec_val;
                end else if (n == 3 && kind == "W") begin
                    wr.addr = rec_addr;
                    wr.data = rec_val;
                    exp_writes.push_back(wr);
                end
            end
        end
        $fclose(fd);
    endtask

    ////////////////////
    // Memory model

    task automatic answer_request();
        if (mem_cmd.we) begin
            check_write(mem_cmd.addr, mem_cmd.wdata);
            mem[mem_cmd.addr] = mem_cmd.wdata;
        end
        mem_rdata   = mem[mem_cmd.addr];
        mem_ack     = 1'b1;
        hold_cycles = 0;
        mem_phase   = mem_acked;
    endtask

    always @(posedge phi0) begin
        #1;
        if (!rst_n) begin
            mem_phase = mem_idle;
            mem_ack   = 1'b0;
        end else begin
            case (mem_phase)
                mem_idle: if (mem_req) begin
                    // Random answer delay of 0 to 5 cycles
                    delay_left = $urandom % 6;
                    if (delay_left == 0) answer_request();
                    else mem_phase = mem_delay;
                end
                mem_delay: begin
                    delay_left--;
                    if (delay_left == 0) answer_request();
                end
                default: if (!mem_req) begin
                    mem_ack   = 1'b0;
                    mem_phase = mem_idle;
                end else begin
                    hold_cycles++;
                    if (hold_cycles > ack_timeout) begin
                        $display("mem_req never fell after mem_ack within %0d cycles",
                                 ack_timeout);
                        stop_with_failure();
                    end
                end
            endcase
        end
    end

    ////////////////////
    // Main sequence

    initial begin
        int cycles;
        void'($urandom(43208));
        rst_n     = 1'b0;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        mem_phase = mem_idle;
        load_testdata();
        repeat (10) @(posedge phi0);
        #1 rst_n = 1'b1;

        cycles = 0;
        while (!halted) begin
            @(posedge phi0);
            #1;
            cycles++;
            if (cycles > halt_timeout) begin
                $display("halted never rose within %0d cycles", halt_timeout);
                stop_with_failure();
            end
        end

        // Core must stay off the bus once halted
        repeat (quiet_cycles) begin
            @(posedge phi0);
            #1;
            if (mem_req) begin
                $display("mem_req rose after the core halted");
                stop_with_failure();
            end
        end

        if (exp_writes.size() != 0) begin
            $display("%0d expected writes never happened", exp_writes.size());
            stop_with_failure();
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

// ==== list.f ====
src/cpu_pkg.sv
src/bus_arbiter.sv
src/fetch_unit.sv
src/exec_unit.sv
src/cpu_top.sv
dv/cpu_asserts.sv
dv/tb_cpu.sv

// ==== src/bus_arbiter.sv ====
// Memory port arbiter with exec-first priority and four-phase handshake pass-through
`timescale 1ns/1ps

module bus_arbiter import cpu_pkg::*; (
    input  logic              phi0,
    input  logic              rst_n,

    input  logic              fetch_req,
    input  mem_cmd_t          fetch_cmd,
    output logic              fetch_ack,

    input  logic              exec_req,
    input  mem_cmd_t          exec_cmd,
    output logic              exec_ack,

    output logic [data_w-1:0] rdata,

    output logic              mem_req,
    output mem_cmd_t          mem_cmd,
    input  logic              mem_ack,
    input  logic [data_w-1:0] mem_rdata
);

    logic busy;
    logic own_exec;
    logic sel_req;

    assign sel_req = own_exec ? exec_req : fetch_req;

    ////////////////////
    // Grant register

    always_ff @(posedge phi0) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            own_exec <= 1'b0;
            mem_req  <= 1'b0;
        end else begin
            // External req trails the owner's req by one cycle
            mem_req <= busy && sel_req;
            if (!busy) begin
                if (!mem_req && !mem_ack && (exec_req || fetch_req)) begin
                    busy     <= 1'b1;
                    own_exec <= exec_req;
                end
            end else if (!sel_req && !mem_req && !mem_ack) begin
                // Whole handshake back to idle
                busy <= 1'b0;
            end
        end
    end

    ////////////////////
    // Port mux

    assign mem_cmd = own_exec ? exec_cmd : fetch_cmd;

    // Ack only reaches the current owner
    assign exec_ack  = busy && own_exec && mem_ack;
    assign fetch_ack = busy && !own_exec && mem_ack;

    assign rdata = mem_rdata;

endmodule

// ==== src/cpu_pkg.sv ====
// Core widths, reset vector, opcode and FSM state enums, bus and instruction structs
package cpu_pkg;

    localparam int addr_w = 16;
    localparam int data_w = 8;

    // First opcode fetch after reset
    localparam logic [addr_w-1:0] reset_vector = 16'h0200;

    // Supported 6502 subset
    typedef enum logic [7:0] {
        op_lda_imm = 8'hA9,
        op_lda_abs = 8'hAD,
        op_sta_abs = 8'h8D,
        op_stx_abs = 8'h8E,
        op_adc_imm = 8'h69,
        op_and_imm = 8'h29,
        op_tax     = 8'hAA,
        op_inx     = 8'hE8,
        op_clc     = 8'h18,
        op_jmp_abs = 8'h4C,
        op_brk     = 8'h00
    } opcode_e;

    typedef enum logic [2:0] {
        f_idle,
        f_opcode,
        f_oper_lo,
        f_oper_hi,
        f_offer,
        f_release,
        f_stopped
    } fetch_state_e;

    typedef enum logic [1:0] {
        e_wait,
        e_mem,
        e_ack,
        e_halted
    } exec_state_e;

    ////////////////////
    // Bus and instruction payloads

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
        logic              we;
    } mem_cmd_t;

    typedef struct packed {
        opcode_e           op;
        logic [addr_w-1:0] operand;
        logic [addr_w-1:0] next_pc;
    } instr_t;

    typedef struct packed {
        logic              valid;
        logic [addr_w-1:0] target;
    } redirect_t;

endpackage

// ==== src/cpu_top.sv ====
// Core top level joining fetch, execute and the memory arbiter
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; (
    input  logic              phi0,
    input  logic              rst_n,

    output logic              mem_req,
    output mem_cmd_t          mem_cmd,
    input  logic              mem_ack,
    input  logic [data_w-1:0] mem_rdata,

    output logic              halted
);

    ////////////////////
    // Internal handshakes

    logic              fetch_req;
    logic              fetch_ack;
    mem_cmd_t          fetch_cmd;
    logic              exec_req;
    logic              exec_ack;
    mem_cmd_t          exec_cmd;
    logic [data_w-1:0] bus_rdata;

    logic              instr_req;
    logic              instr_ack;
    instr_t            instr;
    redirect_t         redirect;

    fetch_unit u_fetch (
        .phi0      (phi0),
        .rst_n     (rst_n),
        .bus_req   (fetch_req),
        .bus_cmd   (fetch_cmd),
        .bus_ack   (fetch_ack),
        .bus_rdata (bus_rdata),
        .instr_req (instr_req),
        .instr     (instr),
        .instr_ack (instr_ack),
        .redirect  (redirect)
    );

    exec_unit u_exec (
        .phi0      (phi0),
        .rst_n     (rst_n),
        .instr_req (instr_req),
        .instr     (instr),
        .instr_ack (instr_ack),
        .redirect  (redirect),
        .bus_req   (exec_req),
        .bus_cmd   (exec_cmd),
        .bus_ack   (exec_ack),
        .bus_rdata (bus_rdata),
        .halted    (halted)
    );

    // Single external port shared by both units
    bus_arbiter u_arb (
        .phi0      (phi0),
        .rst_n     (rst_n),
        .fetch_req (fetch_req),
        .fetch_cmd (fetch_cmd),
        .fetch_ack (fetch_ack),
        .exec_req  (exec_req),
        .exec_cmd  (exec_cmd),
        .exec_ack  (exec_ack),
        .rdata     (bus_rdata),
        .mem_req   (mem_req),
        .mem_cmd   (mem_cmd),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

endmodule

// ==== src/exec_unit.sv ====
// Execute unit with A, X, carry and zero, ALU, data accesses, jump redirect and halt
`timescale 1ns/1ps

module exec_unit import cpu_pkg::*; (
    input  logic              phi0,
    input  logic              rst_n,

    input  logic              instr_req,
    input  instr_t            instr,
    output logic              instr_ack,
    output redirect_t         redirect,

    output logic              bus_req,
    output mem_cmd_t          bus_cmd,
    input  logic              bus_ack,
    input  logic [data_w-1:0] bus_rdata,

    output logic              halted
);

    exec_state_e       state;
    logic [data_w-1:0] a;
    logic [data_w-1:0] x;
    logic              c;
    logic              z;

    logic [data_w-1:0] imm;
    logic [data_w:0]   adc_sum;
    logic [data_w-1:0] and_res;
    logic [data_w-1:0] inx_res;

    ////////////////////
    // ALU

    assign imm     = instr.operand[data_w-1:0];
    assign adc_sum = {1'b0, a} + {1'b0, imm} + {{data_w{1'b0}}, c};
    assign and_res = a & imm;
    // INX wraps at 8 bits
    assign inx_res = x + 1'b1;

    ////////////////////
    // Execute FSM

    always_ff @(posedge phi0) begin
        if (!rst_n) begin
            state          <= e_wait;
            instr_ack      <= 1'b0;
            redirect.valid <= 1'b0;
            bus_req        <= 1'b0;
            bus_cmd.we     <= 1'b0;
            halted         <= 1'b0;
            c              <= 1'b0;
            z              <= 1'b0;
        end else begin
            case (state)
                e_wait: if (instr_req) begin
                    // Register ops ack on the next cycle
                    instr_ack <= 1'b1;
                    state     <= e_ack;
                    case (instr.op)
                        op_lda_imm: begin
                            a <= imm;
                            z <= (imm == '0);
                        end
                        op_adc_imm: begin
                            a <= adc_sum[data_w-1:0];
                            c <= adc_sum[data_w];
                            z <= (adc_sum[data_w-1:0] == '0);
                        end
                        op_and_imm: begin
                            a <= and_res;
                            z <= (and_res == '0);
                        end
                        op_tax: begin
                            x <= a;
                            z <= (a == '0);
                        end
                        op_inx: begin
                            x <= inx_res;
                            z <= (inx_res == '0);
                        end
                        op_clc: c <= 1'b0;
                        op_jmp_abs: begin
                            redirect.valid  <= 1'b1;
                            redirect.target <= instr.operand;
                        end
                        op_lda_abs, op_sta_abs, op_stx_abs: begin
                            // Hold the ack until the data transfer is over
                            instr_ack     <= 1'b0;
                            state         <= e_mem;
                            bus_req       <= 1'b1;
                            bus_cmd.addr  <= instr.operand;
                            bus_cmd.we    <= (instr.op != op_lda_abs);
                            bus_cmd.wdata <= (instr.op == op_stx_abs) ? x : a;
                        end
                        default: begin
                            // BRK or unknown opcode
                            instr_ack <= 1'b0;
                            halted    <= 1'b1;
                            state     <= e_halted;
                        end
                    endcase
                end
                e_mem: if (bus_req && bus_ack) begin
                    bus_req <= 1'b0;
                    if (!bus_cmd.we) begin
                        a <= bus_rdata;
                        z <= (bus_rdata == '0);
                    end
                end else if (!bus_req && !bus_ack) begin
                    instr_ack <= 1'b1;
                    state     <= e_ack;
                end
                e_ack: if (!instr_req) begin
                    instr_ack      <= 1'b0;
                    redirect.valid <= 1'b0;
                    state          <= e_wait;
                end
                default: state <= e_halted;
            endcase
        end
    end

endmodule

// ==== src/fetch_unit.sv ====
// Program counter and instruction fetch FSM feeding the exec unit
`timescale 1ns/1ps

module fetch_unit import cpu_pkg::*; (
    input  logic              phi0,
    input  logic              rst_n,

    output logic              bus_req,
    output mem_cmd_t          bus_cmd,
    input  logic              bus_ack,
    input  logic [data_w-1:0] bus_rdata,

    output logic              instr_req,
    output instr_t            instr,
    input  logic              instr_ack,
    input  redirect_t         redirect
);

    fetch_state_e      state;
    logic [addr_w-1:0] pc;
    logic              reading;

    // Operand length per opcode
    function automatic logic [1:0] operand_bytes(input opcode_e op);
        case (op)
            op_lda_imm, op_adc_imm, op_and_imm: operand_bytes = 2'd1;
            op_lda_abs, op_sta_abs, op_stx_abs, op_jmp_abs: operand_bytes = 2'd2;
            default: operand_bytes = 2'd0;
        endcase
    endfunction

    function automatic logic stops_core(input opcode_e op);
        case (op)
            op_lda_imm, op_lda_abs, op_sta_abs, op_stx_abs, op_adc_imm,
            op_and_imm, op_tax, op_inx, op_clc, op_jmp_abs: stops_core = 1'b0;
            op_brk: stops_core = 1'b1;
            default: stops_core = 1'b1;
        endcase
    endfunction

    assign reading = (state == f_opcode) || (state == f_oper_lo) || (state == f_oper_hi);

    always_ff @(posedge phi0) begin
        if (!rst_n) begin
            state      <= f_idle;
            pc         <= reset_vector;
            bus_req    <= 1'b0;
            bus_cmd.we <= 1'b0;
            instr_req  <= 1'b0;
        end else begin
            // One byte read per read state, started once the last ack is gone
            if (reading && !bus_req && !bus_ack) begin
                bus_req <= 1'b1;
                bus_cmd <= '{addr: pc, wdata: '0, we: 1'b0};
            end
            case (state)
                f_idle: state <= f_opcode;
                f_opcode: if (bus_req && bus_ack) begin
                    bus_req       <= 1'b0;
                    instr.op      <= opcode_e'(bus_rdata);
                    instr.operand <= '0;
                    pc            <= pc + 1'b1;
                    state <= (operand_bytes(opcode_e'(bus_rdata)) == 2'd0) ? f_offer : f_oper_lo;
                end
                f_oper_lo: if (bus_req && bus_ack) begin
                    bus_req                    <= 1'b0;
                    instr.operand[data_w-1:0]  <= bus_rdata;
                    pc                         <= pc + 1'b1;
                    state <= (operand_bytes(instr.op) == 2'd2) ? f_oper_hi : f_offer;
                end
                f_oper_hi: if (bus_req && bus_ack) begin
                    bus_req                        <= 1'b0;
                    instr.operand[addr_w-1:data_w] <= bus_rdata;
                    pc                             <= pc + 1'b1;
                    state                          <= f_offer;
                end
                f_offer: if (!instr_req && !instr_ack) begin
                    instr_req     <= 1'b1;
                    instr.next_pc <= pc;
                    // BRK is never acked, so the offer just stays up
                    if (stops_core(instr.op)) state <= f_stopped;
                end else if (instr_req && instr_ack) begin
                    instr_req <= 1'b0;
                    pc        <= redirect.valid ? redirect.target : instr.next_pc;
                    state     <= f_release;
                end
                f_release: if (!instr_ack) state <= f_idle;
                default: state <= f_stopped;
            endcase
        end
    end

endmodule
